/* io_pkg.sv */
package io_pkg;

  // data bus
  localparam int unsigned addr_width = 8;
  localparam int unsigned data_width = 16;

  // io register map
  localparam logic [addr_width-1:0] addr_led      = 8'h80; // word write also loads lcd
  localparam logic [addr_width-1:0] addr_lcd      = 8'h81; // upper byte
  localparam logic [addr_width-1:0] addr_gpio     = 8'h82;
  localparam logic [addr_width-1:0] addr_gpio_dir = 8'h83; // 1 drives the pin

  // led matrix geometry
  localparam int unsigned num_rows  = 5;
  localparam int unsigned row_width = 3;

  // row scan timing in sys_clk cycles
  localparam int unsigned scan_period = 40;
  localparam int unsigned gap_on      = 2;  // dark cycles at row start
  localparam int unsigned gap_off     = 8;  // dark cycles before next row
  localparam int unsigned cnt_width   = 16;

endpackage

/* io_regs.sv */
`timescale 1ns/1ns

module io_regs import io_pkg::*; (
  input  logic                  sys_clk,
  input  logic                  rst_n,
  input  logic [addr_width-1:0] dmem_addr,
  input  logic                  dmem_wen,
  input  logic                  dmem_byt,
  input  logic [data_width-1:0] dmem_wdata,
  input  logic [7:0]            gpio_in,
  output logic [data_width-1:0] dmem_rdata,
  output logic [7:0]            io_led,
  output logic [7:0]            io_lcd,
  output logic [7:0]            io_gpio,
  output logic [7:0]            io_gpio_dir
);

  logic [7:0]            wdata_lo;
  logic [7:0]            wdata_hi;
  logic                  wr_led;
  logic                  wr_lcd;
  logic                  wr_gpio;
  logic                  wr_dir;
  logic [addr_width-1:0] dmem_addr_d;
  logic [7:0]            gpio_q;

  assign wdata_lo = dmem_wdata[7:0];
  assign wdata_hi = dmem_wdata[data_width-1:8];

  // write strobes
  assign wr_led  = dmem_wen && (dmem_addr == addr_led);
  assign wr_lcd  = dmem_wen && (dmem_addr == addr_lcd);
  assign wr_gpio = dmem_wen && (dmem_addr == addr_gpio);
  assign wr_dir  = dmem_wen && (dmem_addr == addr_gpio_dir);

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      io_led <= 8'd0;
    end else if (wr_led) begin
      io_led <= wdata_lo; // byte and word both hit the led byte
    end
  end

  // lcd takes the high byte of a word write at the led address too
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      io_lcd <= 8'd0;
    end else if ((wr_led && !dmem_byt) || wr_lcd) begin
      io_lcd <= wdata_hi;
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      io_gpio <= 8'd0;
    end else if (wr_gpio) begin
      io_gpio <= wdata_lo;
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      io_gpio_dir <= 8'd0; // all pins released
    end else if (wr_dir) begin
      io_gpio_dir <= wdata_lo;
    end
  end

  // read side runs one cycle behind the address
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      dmem_addr_d <= '0;
    end else begin
      dmem_addr_d <= dmem_addr;
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      gpio_q <= 8'd0;
    end else begin
      gpio_q <= gpio_in; // pins sampled with the address
    end
  end

  always_comb begin
    case (dmem_addr_d)
      addr_led, addr_lcd:       dmem_rdata = {io_lcd, io_led};
      addr_gpio, addr_gpio_dir: dmem_rdata = {io_gpio_dir, gpio_q};
      default:                  dmem_rdata = '0;
    endcase
  end

endmodule

/* led_matrix_scan.sv */
`timescale 1ns/1ns

module led_matrix_scan import io_pkg::*; (
  input  logic                sys_clk,
  input  logic                rst_n,
  input  logic [7:0]          io_led,
  output logic [num_rows-1:0] led_row,
  output logic [7:0]          led_col
);

  localparam logic [cnt_width-1:0] cnt_last  = cnt_width'(scan_period - 1);
  localparam logic [cnt_width-1:0] lit_start = cnt_width'(gap_on);
  localparam logic [cnt_width-1:0] lit_end   = cnt_width'(scan_period - gap_off);
  localparam logic [row_width-1:0] row_last  = row_width'(num_rows - 1);

  logic [cnt_width-1:0] counter;
  logic [row_width-1:0] row_index;
  logic                 row_lit;

  // per-row cycle counter
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      counter <= '0;
    end else if (counter == cnt_last) begin
      counter <= '0;
    end else begin
      counter <= counter + 1'b1;
    end
  end

  // next row when the counter sits at zero
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      row_index <= '0;
    end else if (counter == '0) begin
      if (row_index == row_last) begin
        row_index <= '0;
      end else begin
        row_index <= row_index + 1'b1;
      end
    end
  end

  // dark at both ends of a row so neighbours do not ghost
  assign row_lit = (counter >= lit_start) && (counter < lit_end);

  always_comb begin
    led_row = '1; // active low
    if (row_lit) begin
      led_row[row_index] = 1'b0;
    end
  end

  // fixed one-hot on rows 0 to 3, user byte on the last row
  always_comb begin
    case (row_index)
      3'd0:     led_col = 8'b1000_0000;
      3'd1:     led_col = 8'b0100_0000;
      3'd2:     led_col = 8'b0010_0000;
      3'd3:     led_col = 8'b0001_0000;
      row_last: led_col = io_led;
      default:  led_col = 8'b0000_0000;
    endcase
  end

endmodule

/* io_top.sv */
`timescale 1ns/1ns

module io_top import io_pkg::*; (
  input  logic                  sys_clk,
  input  logic                  rst_n,
  // cpu data bus
  input  logic [addr_width-1:0] dmem_addr,
  input  logic                  dmem_wen,
  input  logic                  dmem_byt,
  input  logic [data_width-1:0] dmem_wdata,
  output logic [data_width-1:0] dmem_rdata,
  // led matrix
  output logic [num_rows-1:0]   led_row,
  output logic [7:0]            led_col,
  // hd44780 in 4-bit mode
  output logic                  lcd_e,
  output logic                  lcd_rw,
  output logic                  lcd_rs,
  output logic [7:4]            lcd_db,
  inout  wire  [7:0]            gpio
);

  logic [7:0] io_led;
  logic [7:0] io_lcd;
  logic [7:0] io_gpio;
  logic [7:0] io_gpio_dir;
  logic [7:0] gpio_in;

  io_regs i_regs (
    .sys_clk     (sys_clk),
    .rst_n       (rst_n),
    .dmem_addr   (dmem_addr),
    .dmem_wen    (dmem_wen),
    .dmem_byt    (dmem_byt),
    .dmem_wdata  (dmem_wdata),
    .gpio_in     (gpio_in),
    .dmem_rdata  (dmem_rdata),
    .io_led      (io_led),
    .io_lcd      (io_lcd),
    .io_gpio     (io_gpio),
    .io_gpio_dir (io_gpio_dir)
  );

  led_matrix_scan i_scan (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .io_led  (io_led),
    .led_row (led_row),
    .led_col (led_col)
  );

  // lcd pin split, bit 3 unused
  assign lcd_e  = io_lcd[0];
  assign lcd_rw = io_lcd[1];
  assign lcd_rs = io_lcd[2];
  assign lcd_db = io_lcd[7:4];

  // each pin driven only where its direction bit is set
  for (genvar i = 0; i < 8; i++) begin : g_gpio
    assign gpio[i] = io_gpio_dir[i] ? io_gpio[i] : 1'bz;
  end

  assign gpio_in = gpio; // reads back driven and external values alike

endmodule

/* tb_io_checks.svh */
`ifndef TB_IO_CHECKS_SVH
`define TB_IO_CHECKS_SVH

  task automatic check_rdata(input logic [data_width-1:0] got, input logic [data_width-1:0] exp,
                             input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_col(input logic [7:0] got, input logic [7:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t: %s led_col %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_row(input logic [num_rows-1:0] got, input logic [num_rows-1:0] exp,
                           input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t: %s led_row %b, expected %b", $time, what, got, exp);
    end
  endtask

  // 4-state compare, released pins read z
  task automatic check_pins(input logic [7:0] got, input logic [7:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t: %s are %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_length(input int got, input int exp, input string what);
    check_count++;
    if (got != exp) begin
      err_count++;
      $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    $display("test %s finished with %0d errors", name, err_count - errs_before);
  endtask

  task automatic test_reset_state();
    logic [data_width-1:0] rd;
    int                    errs;
    errs = err_count;
    check_row(led_row, '1, "in reset");
    check_pins(lcd_pins(), 8'h00, "lcd pins in reset");
    check_pins(gpio, 8'hzz, "gpio pins in reset");
    rst_n   = 1'b1;
    ext_en  = 8'hff; // pins held low from outside
    ext_val = 8'h00;
    for (int a = 0; a < 4; a++) begin
      bus_read(addr_width'(addr_led + a), rd);
      check_rdata(rd, 16'h0000, $sformatf("register %0d after reset", a));
    end
    finish_test("reset_state", errs);
  endtask

  task automatic test_word_byte();
    logic [31:0]           r;
    logic [data_width-1:0] w;
    logic [data_width-1:0] rd;
    int                    errs;
    errs = err_count;
    random_bits(16, r);
    w = r[15:0];
    bus_write(addr_led, w, 1'b0);
    check_pins(lcd_pins(), {w[15:12], 1'b0, w[10:8]}, "lcd pins after word write");
    bus_read(addr_led, rd);
    check_rdata(rd, w, "word at 80");
    bus_read(addr_lcd, rd);
    check_rdata(rd, w, "word at 81");
    random_bits(16, r);
    bus_write(addr_led, r[15:0], 1'b1); // led byte only
    w = {w[15:8], r[7:0]};
    bus_read(addr_led, rd);
    check_rdata(rd, w, "byte write at 80");
    random_bits(16, r);
    bus_write(addr_lcd, r[15:0], 1'b0);
    w = {r[15:8], w[7:0]};
    bus_read(addr_lcd, rd);
    check_rdata(rd, w, "write at 81");
    check_pins(lcd_pins(), {w[15:12], 1'b0, w[10:8]}, "lcd pins after write at 81");
    bus_read(8'h10, rd);
    check_rdata(rd, 16'h0000, "unmapped 10");
    bus_read(8'h84, rd);
    check_rdata(rd, 16'h0000, "unmapped 84");
    finish_test("word_byte", errs);
  endtask

  task automatic test_back_to_back();
    logic [31:0]           r;
    logic [data_width-1:0] rd;
    int                    errs;
    errs = err_count;
    random_bits(8, r);
    ext_val = r[7:0];
    random_bits(8, r);
    bus_write(addr_gpio, {8'h00, r[7:0]}, 1'b0);
    dmem_addr = 8'h7e;
    next_cycle();
    for (int a = 'h7e; a <= 'h85; a++) begin
      dmem_addr = addr_width'(a + 1); // next read already on the bus
      @(negedge sys_clk);
      rd = dmem_rdata;
      check_rdata(rd, expected_word(addr_width'(a)), $sformatf("pipelined read %h", a));
      next_cycle();
    end
    random_bits(16, r);
    bus_write(addr_led, r[15:0], 1'b0);
    bus_read(addr_led, rd); // straight after the write
    check_rdata(rd, r[15:0], "read right after write");
    finish_test("back_to_back", errs);
  endtask

  task automatic test_gpio();
    logic [31:0]           r;
    logic [7:0]            mask;
    logic [7:0]            out;
    logic [7:0]            pins;
    logic [data_width-1:0] rd;
    int                    errs;
    errs = err_count;
    for (int n = 0; n < 3; n++) begin
      random_bits(8, r);
      mask = r[7:0];
      random_bits(8, r);
      out = r[7:0];
      random_bits(8, r);
      ext_en  = ext_en & ~mask; // let go before the DUT takes over
      ext_val = r[7:0];
      bus_write(addr_gpio_dir, {8'h00, mask}, 1'b0);
      ext_en = ~mask;
      bus_write(addr_gpio, {8'h00, out}, 1'b0);
      pins = (mask & out) | (~mask & ext_val);
      check_pins(gpio, pins, $sformatf("gpio pins, mask %b", mask));
      bus_read(addr_gpio, rd);
      check_rdata(rd, {mask, pins}, "gpio at 82");
      bus_read(addr_gpio_dir, rd);
      check_rdata(rd, {mask, pins}, "gpio at 83");
    end
    finish_test("gpio", errs);
  endtask

  task automatic test_matrix_scan();
    logic [31:0]         r;
    logic [num_rows-1:0] one_low;
    logic                rewritten;
    int                  errs;
    int                  cycles;
    int                  run_len;
    int                  runs;
    int                  row;
    errs = err_count;
    random_bits(8, r);
    bus_write(addr_led, {8'h00, r[7:0]}, 1'b1);
    cycles = 0;
    while (led_row !== '1 && cycles < wait_limit) begin
      next_cycle();
      cycles++;
    end
    while (led_row[0] !== 1'b0 && cycles < wait_limit) begin
      next_cycle();
      cycles++;
    end
    if (cycles >= wait_limit) begin
      err_count++;
      $display("timeout: row 0 of the LED matrix never lit");
    end else begin
      row       = 0;
      run_len   = 0;
      runs      = 0;
      rewritten = 1'b0;
      cycles    = 0;
      while (runs < 2 * num_rows && cycles < wait_limit) begin
        if (led_row !== '1) begin
          one_low = ~(num_rows'(1) << row);
          check_row(led_row, one_low, $sformatf("row %0d lit", row));
          check_col(led_col, row_pattern(row), $sformatf("row %0d", row));
          run_len++;
        end else if (run_len != 0) begin
          check_length(run_len, lit_len, $sformatf("lit run of row %0d", row));
          runs++;
          run_len = 0;
          row = (row + 1) % num_rows;
        end
        if (runs == num_rows && !rewritten) begin
          random_bits(8, r);
          bus_write(addr_led, {8'h00, r[7:0]}, 1'b1); // second frame shows the new byte
          rewritten = 1'b1;
        end else begin
          next_cycle();
        end
        cycles++;
      end
      if (runs < 2 * num_rows) begin
        err_count++;
        $display("timeout: saw only %0d of %0d lit rows in two frames", runs, 2 * num_rows);
      end
    end
    finish_test("matrix_scan", errs);
  endtask

`endif

/* tb_io_top.sv */
`timescale 1ns/1ns

module tb_io_top import io_pkg::*; ();

  localparam int wait_limit = 4 * num_rows * scan_period;
  localparam int lit_len    = scan_period - gap_on - gap_off;

  logic                  sys_clk;
  logic                  rst_n;
  logic [addr_width-1:0] dmem_addr;
  logic                  dmem_wen;
  logic                  dmem_byt;
  logic [data_width-1:0] dmem_wdata;
  logic [data_width-1:0] dmem_rdata;
  logic [num_rows-1:0]   led_row;
  logic [7:0]            led_col;
  logic                  lcd_e;
  logic                  lcd_rw;
  logic                  lcd_rs;
  logic [7:4]            lcd_db;
  wire  [7:0]            gpio;

  // external driver on the gpio pins
  logic [7:0] ext_en;
  logic [7:0] ext_val;

  // expected register contents
  logic [7:0] exp_led;
  logic [7:0] exp_lcd;
  logic [7:0] exp_gpio;
  logic [7:0] exp_dir;

  logic [31:0] lfsr_state;
  int          err_count;
  int          check_count;

  always #5 sys_clk = ~sys_clk;

  for (genvar i = 0; i < 8; i++) begin : g_ext
    assign gpio[i] = ext_en[i] ? ext_val[i] : 1'bz;
  end

  io_top i_dut (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .dmem_addr  (dmem_addr),
    .dmem_wen   (dmem_wen),
    .dmem_byt   (dmem_byt),
    .dmem_wdata (dmem_wdata),
    .dmem_rdata (dmem_rdata),
    .led_row    (led_row),
    .led_col    (led_col),
    .lcd_e      (lcd_e),
    .lcd_rw     (lcd_rw),
    .lcd_rs     (lcd_rs),
    .lcd_db     (lcd_db),
    .gpio       (gpio)
  );

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  // inputs change 1 ns after the edge
  task automatic next_cycle();
    @(posedge sys_clk);
    #1;
  endtask

  task automatic bus_write(input logic [addr_width-1:0] addr,
                           input logic [data_width-1:0] data, input logic byt);
    dmem_addr  = addr;
    dmem_wen   = 1'b1;
    dmem_byt   = byt;
    dmem_wdata = data;
    next_cycle();
    dmem_wen = 1'b0;
    dmem_byt = 1'b0;
    case (addr)
      addr_led: begin
        exp_led = data[7:0];
        if (!byt) exp_lcd = data[15:8];
      end
      addr_lcd:      exp_lcd  = data[15:8];
      addr_gpio:     exp_gpio = data[7:0];
      addr_gpio_dir: exp_dir  = data[7:0];
      default: ;
    endcase
  endtask

  // data shows up one cycle after the address
  task automatic bus_read(input logic [addr_width-1:0] addr,
                          output logic [data_width-1:0] data);
    dmem_addr = addr;
    dmem_wen  = 1'b0;
    next_cycle();
    data = dmem_rdata;
  endtask

  function automatic logic [7:0] expected_pins();
    logic [7:0] p;
    for (int i = 0; i < 8; i++) begin
      p[i] = exp_dir[i] ? exp_gpio[i] : (ext_en[i] ? ext_val[i] : 1'bz);
    end
    return p;
  endfunction

  function automatic logic [data_width-1:0] expected_word(input logic [addr_width-1:0] addr);
    case (addr)
      addr_led, addr_lcd:       return {exp_lcd, exp_led};
      addr_gpio, addr_gpio_dir: return {exp_dir, expected_pins()};
      default:                  return '0;
    endcase
  endfunction

  function automatic logic [7:0] row_pattern(input int row);
    if (row == num_rows - 1) return exp_led;
    return 8'h80 >> row;
  endfunction

  function automatic logic [7:0] lcd_pins();
    return {lcd_db, 1'b0, lcd_rs, lcd_rw, lcd_e}; // bit 3 not wired
  endfunction

  `include "tb_io_checks.svh"

  initial begin
    sys_clk     = 1'b0;
    rst_n       = 1'b0;
    dmem_addr   = '0;
    dmem_wen    = 1'b0;
    dmem_byt    = 1'b0;
    dmem_wdata  = '0;
    ext_en      = 8'h00;
    ext_val     = 8'h00;
    exp_led     = 8'h00;
    exp_lcd     = 8'h00;
    exp_gpio    = 8'h00;
    exp_dir     = 8'h00;
    lfsr_state  = 32'h594b0700;
    err_count   = 0;
    check_count = 0;
    repeat (10) @(posedge sys_clk);
    #1;
    test_reset_state();
    test_word_byte();
    test_back_to_back();
    test_gpio();
    test_matrix_scan();
    $display("%0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+.
io_pkg.sv
io_regs.sv
led_matrix_scan.sv
io_top.sv
tb_io_top.sv

/* Bender.yml */
package:
  name: mcu_io

sources:
  # rtl, package first
  - files:
      - io_pkg.sv
      - io_regs.sv
      - led_matrix_scan.sv
      - io_top.sv
  # testbench, top module tb_io_top
  - target: test
    include_dirs:
      - .
    files:
      - tb_io_top.sv
